/* verilog/rv_pkg.sv */
// RV32I datapath slice shared definitions
// Instruction word views, major opcodes, funct fields and ALU operation codes
package rv_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int ALU_OP_W   = 4;

    // One instruction word, seen as R-format or I-format
    typedef union packed {
        struct packed {
            logic [6:0]            funct7;
            logic [REG_ADDR_W-1:0] rs2;
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } r;
        struct packed {
            logic [11:0]           imm;      // Upper fields double as the U-immediate
            logic [REG_ADDR_W-1:0] rs1;
            logic [2:0]            funct3;
            logic [REG_ADDR_W-1:0] rd;
            logic [6:0]            opcode;
        } i;
    } inst_word_u;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;   // Selects SUB and SRA

    localparam logic [ALU_OP_W-1:0] ALU_ADD   = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_SUB   = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_AND   = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OR    = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_XOR   = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_SLL   = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_SRL   = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_SRA   = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_SLT   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_SLTU  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_COPY2 = 4'd10;   // Operand 2 straight through

endpackage

/* verilog/decode_stage.sv */
// Decode stage of the RV32I datapath slice
// Matches the presented word against the instruction table, builds both
// operands and loads the execute register, stalling on pending writes
`timescale 1ns/1ps

module decode_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inst_valid,
    input  logic [rv_pkg::XLEN-1:0]       inst,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    input  logic [rv_pkg::XLEN-1:0]       rs1_data,
    input  logic [rv_pkg::XLEN-1:0]       rs2_data,
    input  logic                          res_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] res_rd,
    output logic                          stall,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
    output logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic                          exe_valid,
    output logic [rv_pkg::ALU_OP_W-1:0]   exe_alu_op,
    output logic [rv_pkg::REG_ADDR_W-1:0] exe_rd,
    output logic [rv_pkg::XLEN-1:0]       exe_op1,
    output logic [rv_pkg::XLEN-1:0]       exe_op2
);
    import rv_pkg::*;

    localparam logic [1:0] OP1_RS1   = 2'd0;
    localparam logic [1:0] OP1_PC    = 2'd1;
    localparam logic [1:0] OP1_ZERO  = 2'd2;
    localparam logic [1:0] OP2_RS2   = 2'd0;
    localparam logic [1:0] OP2_IMI   = 2'd1;
    localparam logic [1:0] OP2_SHAMT = 2'd2;
    localparam logic [1:0] OP2_IMU   = 2'd3;
    localparam int         CTRL_W    = ALU_OP_W + 2 + 2 + 1;

    // Control word is {alu_op, op1_sel, op2_sel, rf_wen}
    function automatic logic [CTRL_W-1:0] decode(input inst_word_u w);
        casez ({w.r.funct7, w.r.funct3, w.r.opcode})
            {F7_BASE,    F3_ADD_SUB, OPC_OP}:     decode = {ALU_ADD,   OP1_RS1,  OP2_RS2,   1'b1};
            {F7_ALT,     F3_ADD_SUB, OPC_OP}:     decode = {ALU_SUB,   OP1_RS1,  OP2_RS2,   1'b1};
            {F7_BASE,    F3_AND,     OPC_OP}:     decode = {ALU_AND,   OP1_RS1,  OP2_RS2,   1'b1};
            {F7_BASE,    F3_OR,      OPC_OP}:     decode = {ALU_OR,    OP1_RS1,  OP2_RS2,   1'b1};
            {F7_BASE,    F3_XOR,     OPC_OP}:     decode = {ALU_XOR,   OP1_RS1,  OP2_RS2,   1'b1};
            {F7_BASE,    F3_SLL,     OPC_OP}:     decode = {ALU_SLL,   OP1_RS1,  OP2_RS2,   1'b1};
            {F7_BASE,    F3_SR,      OPC_OP}:     decode = {ALU_SRL,   OP1_RS1,  OP2_RS2,   1'b1};
            {F7_ALT,     F3_SR,      OPC_OP}:     decode = {ALU_SRA,   OP1_RS1,  OP2_RS2,   1'b1};
            {F7_BASE,    F3_SLT,     OPC_OP}:     decode = {ALU_SLT,   OP1_RS1,  OP2_RS2,   1'b1};
            {F7_BASE,    F3_SLTU,    OPC_OP}:     decode = {ALU_SLTU,  OP1_RS1,  OP2_RS2,   1'b1};
            {7'b???????, F3_ADD_SUB, OPC_OP_IMM}: decode = {ALU_ADD,   OP1_RS1,  OP2_IMI,   1'b1};
            {7'b???????, F3_AND,     OPC_OP_IMM}: decode = {ALU_AND,   OP1_RS1,  OP2_IMI,   1'b1};
            {7'b???????, F3_OR,      OPC_OP_IMM}: decode = {ALU_OR,    OP1_RS1,  OP2_IMI,   1'b1};
            {7'b???????, F3_XOR,     OPC_OP_IMM}: decode = {ALU_XOR,   OP1_RS1,  OP2_IMI,   1'b1};
            {7'b???????, F3_SLT,     OPC_OP_IMM}: decode = {ALU_SLT,   OP1_RS1,  OP2_IMI,   1'b1};
            {7'b???????, F3_SLTU,    OPC_OP_IMM}: decode = {ALU_SLTU,  OP1_RS1,  OP2_IMI,   1'b1};
            {F7_BASE,    F3_SLL,     OPC_OP_IMM}: decode = {ALU_SLL,   OP1_RS1,  OP2_SHAMT, 1'b1};
            {F7_BASE,    F3_SR,      OPC_OP_IMM}: decode = {ALU_SRL,   OP1_RS1,  OP2_SHAMT, 1'b1};
            {F7_ALT,     F3_SR,      OPC_OP_IMM}: decode = {ALU_SRA,   OP1_RS1,  OP2_SHAMT, 1'b1};
            {7'b???????, 3'b???,     OPC_LUI}:    decode = {ALU_COPY2, OP1_ZERO, OP2_IMU,   1'b1};
            {7'b???????, 3'b???,     OPC_AUIPC}:  decode = {ALU_ADD,   OP1_PC,   OP2_IMU,   1'b1};
            default:                              decode = {ALU_ADD,   OP1_ZERO, OP2_IMI,   1'b0};
        endcase
    endfunction

    inst_word_u          iw;
    logic [ALU_OP_W-1:0] alu_op;
    logic [1:0]          op1_sel;
    logic [1:0]          op2_sel;
    logic                rf_wen;
    logic [XLEN-1:0]     imm_i_sext;
    logic [XLEN-1:0]     imm_u_shifted;
    logic [XLEN-1:0]     op1;
    logic [XLEN-1:0]     op2;
    logic                hazard_rs1;
    logic                hazard_rs2;
    logic                accept;

    assign iw = inst;
    assign {alu_op, op1_sel, op2_sel, rf_wen} = decode(iw);

    assign rs1_addr      = iw.r.rs1;
    assign rs2_addr      = iw.r.rs2;
    assign imm_i_sext    = {{(XLEN-12){iw.i.imm[11]}}, iw.i.imm};
    assign imm_u_shifted = {iw.i.imm, iw.i.rs1, iw.i.funct3, 12'b0};

    // No bypass, so any source still waiting in execute or result blocks issue
    assign hazard_rs1 = (rs1_addr != '0) &&
                        ((exe_valid && exe_rd == rs1_addr) || (res_valid && res_rd == rs1_addr));
    assign hazard_rs2 = (rs2_addr != '0) &&
                        ((exe_valid && exe_rd == rs2_addr) || (res_valid && res_rd == rs2_addr));
    assign stall  = inst_valid && (hazard_rs1 || hazard_rs2);
    assign accept = inst_valid && !stall;

    always_comb begin
        case (op1_sel)
            OP1_PC:   op1 = pc;
            OP1_ZERO: op1 = '0;
            default:  op1 = rs1_data;
        endcase
        case (op2_sel)
            OP2_IMI:   op2 = imm_i_sext;
            OP2_SHAMT: op2 = {{(XLEN-5){1'b0}}, iw.i.imm[4:0]};
            OP2_IMU:   op2 = imm_u_shifted;
            default:   op2 = rs2_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= accept && rf_wen && (iw.r.rd != '0);   // Nops and x0 writes go as bubbles
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exe_alu_op <= alu_op;
            exe_rd     <= iw.r.rd;
            exe_op1    <= op1;
            exe_op2    <= op2;
        end
    end

    // A stalled instruction stays on the inputs until it issues
    a_hold_while_stalled: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> inst_valid && $stable(inst) && $stable(pc));

endmodule

/* verilog/execute_stage.sv */
// Execute stage of the RV32I datapath slice
// ALU over the execute register and the result pipeline register
`timescale 1ns/1ps

module execute_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          exe_valid,
    input  logic [rv_pkg::ALU_OP_W-1:0]   exe_alu_op,
    input  logic [rv_pkg::REG_ADDR_W-1:0] exe_rd,
    input  logic [rv_pkg::XLEN-1:0]       exe_op1,
    input  logic [rv_pkg::XLEN-1:0]       exe_op2,
    output logic                          res_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] res_rd,
    output logic [rv_pkg::XLEN-1:0]       res_data
);
    import rv_pkg::*;

    localparam int SHAMT_W = $clog2(XLEN);

    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]    alu_out;

    assign shamt = exe_op2[SHAMT_W-1:0];   // RV32I shifts use only the low bits

    always_comb begin
        case (exe_alu_op)
            ALU_ADD:   alu_out = exe_op1 + exe_op2;
            ALU_SUB:   alu_out = exe_op1 - exe_op2;
            ALU_AND:   alu_out = exe_op1 & exe_op2;
            ALU_OR:    alu_out = exe_op1 | exe_op2;
            ALU_XOR:   alu_out = exe_op1 ^ exe_op2;
            ALU_SLL:   alu_out = exe_op1 << shamt;
            ALU_SRL:   alu_out = exe_op1 >> shamt;
            ALU_SRA:   alu_out = $signed(exe_op1) >>> shamt;
            ALU_SLT:   alu_out = {{(XLEN-1){1'b0}}, $signed(exe_op1) < $signed(exe_op2)};
            ALU_SLTU:  alu_out = {{(XLEN-1){1'b0}}, exe_op1 < exe_op2};
            ALU_COPY2: alu_out = exe_op2;
            default:   alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= exe_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_valid) begin
            res_rd   <= exe_rd;
            res_data <= alu_out;
        end
    end

    // The execute register has no reset, so a valid entry must carry loaded fields
    a_exe_fields_known: assert property (@(posedge clk) disable iff (!rst_n)
        exe_valid |-> !$isunknown({exe_alu_op, exe_rd, exe_op1, exe_op2}));

endmodule

/* verilog/writeback_stage.sv */
// Result stage of the RV32I datapath slice
// Register file with two read ports, written from the result register,
// and the report of each write
`timescale 1ns/1ps

module writeback_stage (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          res_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] res_rd,
    input  logic [rv_pkg::XLEN-1:0]       res_data,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
    input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
    output logic [rv_pkg::XLEN-1:0]       rs1_data,
    output logic [rv_pkg::XLEN-1:0]       rs2_data,
    output logic                          wb_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [rv_pkg::XLEN-1:0]       wb_data
);
    import rv_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    logic [XLEN-1:0] regs [1:NUM_REGS-1];   // x0 has no storage
    logic            wr_en;

    assign wr_en = res_valid && (res_rd != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[res_rd] <= res_data;
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    assign wb_valid = wr_en;
    assign wb_addr  = res_rd;
    assign wb_data  = res_data;

    // Decode only lets writing instructions to a real register through
    a_no_x0_write: assert property (@(posedge clk) disable iff (!rst_n)
        res_valid |-> res_rd != '0);

endmodule

/* verilog/rv_core_top.sv */
// RV32I integer datapath slice
// Decode, execute and result stages chained into a three-stage pipeline
`timescale 1ns/1ps

module rv_core_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inst_valid,
    input  logic [rv_pkg::XLEN-1:0]       inst,
    input  logic [rv_pkg::XLEN-1:0]       pc,
    output logic                          stall,
    output logic                          wb_valid,
    output logic [rv_pkg::REG_ADDR_W-1:0] wb_addr,
    output logic [rv_pkg::XLEN-1:0]       wb_data
);
    import rv_pkg::*;

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic                  exe_valid;
    logic [ALU_OP_W-1:0]   exe_alu_op;
    logic [REG_ADDR_W-1:0] exe_rd;
    logic [XLEN-1:0]       exe_op1;
    logic [XLEN-1:0]       exe_op2;
    logic                  res_valid;
    logic [REG_ADDR_W-1:0] res_rd;
    logic [XLEN-1:0]       res_data;

    decode_stage decode_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .res_valid  (res_valid),
        .res_rd     (res_rd),
        .stall      (stall),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .exe_valid  (exe_valid),
        .exe_alu_op (exe_alu_op),
        .exe_rd     (exe_rd),
        .exe_op1    (exe_op1),
        .exe_op2    (exe_op2)
    );

    execute_stage execute_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .exe_valid  (exe_valid),
        .exe_alu_op (exe_alu_op),
        .exe_rd     (exe_rd),
        .exe_op1    (exe_op1),
        .exe_op2    (exe_op2),
        .res_valid  (res_valid),
        .res_rd     (res_rd),
        .res_data   (res_data)
    );

    writeback_stage writeback_stage_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .res_valid (res_valid),
        .res_rd    (res_rd),
        .res_data  (res_data),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .wb_valid  (wb_valid),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data)
    );

endmodule

/* tb/wb_checker.sv */
// Checker for the RV32I datapath slice
// Follows accepted instructions through execute and result using the expected
// list, and compares the stall level and each write report cycle by cycle
`timescale 1ns/1ps

module wb_checker #(
    parameter int MAX_CASES = 64
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          inst_valid,
    input  logic [rv_pkg::XLEN-1:0]       inst,
    input  logic                          stall,
    input  logic                          wb_valid,
    input  logic [rv_pkg::REG_ADDR_W-1:0] wb_addr,
    input  logic [rv_pkg::XLEN-1:0]       wb_data,
    input  int                            num_cases,
    input  logic [rv_pkg::REG_ADDR_W-1:0] exp_rd [MAX_CASES],
    input  logic [rv_pkg::XLEN-1:0]       exp_val [MAX_CASES],
    output int                            data_errors,
    output int                            stall_errors,
    output int                            pulses,
    output int                            accepted
);
    import rv_pkg::*;

    logic                  exe_v;
    logic [REG_ADDR_W-1:0] exe_rd;
    int                    exe_idx;
    logic                  res_v;
    logic [REG_ADDR_W-1:0] res_rd;
    int                    res_idx;

    // A source is busy while its writer sits in execute or awaits write-back
    function automatic logic source_busy(input logic [REG_ADDR_W-1:0] src);
        return (src != '0) && ((exe_v && exe_rd == src) || (res_v && res_rd == src));
    endfunction

    always @(posedge clk) begin
        inst_word_u word;
        logic       stall_exp;
        int         n_data;
        int         n_stall;
        word    = inst;
        n_data  = 0;
        n_stall = 0;
        if (!rst_n) begin
            exe_v        <= 1'b0;
            res_v        <= 1'b0;
            data_errors  <= 0;
            stall_errors <= 0;
            pulses       <= 0;
            accepted     <= 0;
        end else begin
            stall_exp = inst_valid && (source_busy(word.r.rs1) || source_busy(word.r.rs2));
            if (stall !== stall_exp) begin
                $display("CHECK FAILED at %0t: stall is %b, expected %b for word %h",
                         $time, stall, stall_exp, inst);
                n_stall = 1;
            end
            if (wb_valid) begin
                pulses <= pulses + 1;
                if (!res_v) begin
                    $display("CHECK FAILED at %0t: write of %h to x%0d with none expected",
                             $time, wb_data, wb_addr);
                    n_data++;
                end else if (wb_addr !== res_rd || wb_data !== exp_val[res_idx]) begin
                    $display("CHECK FAILED at %0t: case %0d wrote x%0d = %h, expected x%0d = %h",
                             $time, res_idx, wb_addr, wb_data, res_rd, exp_val[res_idx]);
                    n_data++;
                end
            end else if (res_v) begin
                $display("CHECK FAILED at %0t: case %0d reported no write, expected x%0d = %h",
                         $time, res_idx, res_rd, exp_val[res_idx]);
                n_data++;
            end
            res_v   <= exe_v;
            res_rd  <= exe_rd;
            res_idx <= exe_idx;
            exe_v   <= 1'b0;
            if (inst_valid && !stall) begin
                if (accepted >= num_cases) begin
                    $display("More instructions were accepted than the case list holds");
                    n_data++;
                end else begin
                    exe_v   <= exp_rd[accepted] != '0;
                    exe_rd  <= exp_rd[accepted];
                    exe_idx <= accepted;
                end
                accepted <= accepted + 1;
            end
            data_errors  <= data_errors + n_data;
            stall_errors <= stall_errors + n_stall;
        end
    end

endmodule

/* tb/tb_top.sv */
// Testbench for the RV32I datapath slice
// Drives instructions from the case file, holds each one through stalls,
// and closes with the error counts gathered by the checker
`timescale 1ns/1ps

module tb_top;
    import rv_pkg::*;

    localparam int MAX_CASES   = 64;
    localparam int COLS        = 5;   // inst, pc, gap, rd, value
    localparam int HALF_PERIOD = 50;

    logic                  clk;
    logic                  rst_n;
    logic                  inst_valid;
    logic [XLEN-1:0]       inst;
    logic [XLEN-1:0]       pc;
    logic                  stall;
    logic                  wb_valid;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [XLEN-1:0]       wb_data;

    logic [31:0]           case_mem [MAX_CASES*COLS];
    logic [REG_ADDR_W-1:0] exp_rd [MAX_CASES];
    logic [XLEN-1:0]       exp_val [MAX_CASES];
    int                    num_cases;
    int                    num_writes;
    int                    data_errors;
    int                    stall_errors;
    int                    count_errors;
    int                    pulses;
    int                    accepted;
    logic [31:0]           rng_state;

    rv_core_top rv_core_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .pc         (pc),
        .stall      (stall),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    wb_checker #(.MAX_CASES(MAX_CASES)) wb_checker_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .stall        (stall),
        .wb_valid     (wb_valid),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .num_cases    (num_cases),
        .exp_rd       (exp_rd),
        .exp_val      (exp_val),
        .data_errors  (data_errors),
        .stall_errors (stall_errors),
        .pulses       (pulses),
        .accepted     (accepted)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Unread entries keep the all-ones pc, which ends the list
    task automatic load_cases();
        for (int i = 0; i < MAX_CASES*COLS; i++) begin
            case_mem[i] = '1;
        end
        $readmemh("tb/alu_cases.txt", case_mem);
        num_cases  = 0;
        num_writes = 0;
        while (num_cases < MAX_CASES && case_mem[num_cases*COLS+1] != '1) begin
            exp_rd[num_cases]  = case_mem[num_cases*COLS+3][REG_ADDR_W-1:0];
            exp_val[num_cases] = case_mem[num_cases*COLS+4];
            if (exp_rd[num_cases] != '0) begin
                num_writes++;
            end
            num_cases++;
        end
    endtask

    task automatic run_case(input int k);
        int gap;
        @(negedge clk);
        inst_valid = 1'b1;
        inst       = case_mem[k*COLS];
        pc         = case_mem[k*COLS+1];
        @(posedge clk);
        while (stall) begin
            @(posedge clk);
        end
        gap = $signed(case_mem[k*COLS+2]);
        if (gap < 0) begin
            rng_state = xorshift32(rng_state);
            gap       = rng_state[0] ? 1 : 0;   // Negative count asks for a random gap
        end
        repeat (gap) begin
            @(negedge clk);
            inst_valid = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n        = 1'b0;
        inst_valid   = 1'b0;
        inst         = '0;
        pc           = '0;
        rng_state    = 32'd5614;
        count_errors = 0;
        load_cases();
        if (num_cases == 0) begin
            $display("No cases could be read from tb/alu_cases.txt");
            $display("Testbench failed");
            $finish;
        end else begin
            repeat (5) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int k = 0; k < num_cases; k++) begin
                run_case(k);
            end
            @(negedge clk);
            inst_valid = 1'b0;
            repeat (3) @(posedge clk);   // Last write is reported two edges after accept
            @(negedge clk);
            if (pulses != num_writes || accepted != num_cases) begin
                $display("CHECK FAILED at %0t: %0d write reports and %0d accepts, expected %0d and %0d",
                         $time, pulses, accepted, num_writes, num_cases);
                count_errors = 1;
            end
            $display("Errors: data %0d, stall %0d, count %0d over %0d cases and %0d writes",
                     data_errors, stall_errors, count_errors, num_cases, num_writes);
            if (data_errors + stall_errors + count_errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

    // Each case needs at most one accept, two stalls and one idle cycle
    initial begin
        int limit;
        @(posedge rst_n);
        limit = num_cases * 4 + 50;
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles after reset", limit);
        $display("Testbench failed");
        $finish;
    end

endmodule

/* tb/alu_cases.txt */
// inst     pc       gap      rd       value
// gap ffffffff asks for a random idle gap, rd 0 means no write is expected
ffb00093 00000000 00000000 00000001 fffffffb
12300113 00000004 00000000 00000002 00000123
0f017193 00000008 ffffffff 00000003 00000020
0040e213 0000000c 00000000 00000004 ffffffff
85514293 00000010 00000001 00000005 fffff976
ffc0a313 00000014 ffffffff 00000006 00000001
fff13393 00000018 00000000 00000007 00000001
00411413 0000001c ffffffff 00000008 00001230
01c0d493 00000020 00000000 00000009 0000000f
4010d513 00000024 ffffffff 0000000a fffffffd
002085b3 00000028 00000000 0000000b 0000011e
40208633 0000002c 00000000 0000000c fffffed8
002626b3 00000030 00000000 0000000d 00000001
00263733 00000034 ffffffff 0000000e 00000000
406657b3 00000038 00000000 0000000f ffffff6c
00965833 0000003c 00000000 00000010 0001ffff
009118b3 00000040 00000001 00000011 00918000
0082f933 00000044 00000000 00000012 00001030
0084e9b3 00000048 00000000 00000013 0000123f
00b9ca33 0000004c 00000000 00000014 00001321
abcdeab7 00000050 ffffffff 00000015 abcde000
00001b17 00000054 00000000 00000016 00001054
ffffffff 00000058 00000000 00000000 00000000
00508013 0000005c 00000001 00000000 00000000
06400b93 00000060 00000000 00000017 00000064
fff00c13 00000064 00000000 00000018 ffffffff
017b8cb3 00000068 ffffffff 00000019 000000c8
419c0d33 0000006c 00000000 0000001a ffffff37
01a03db3 00000070 00000000 0000001b 00000001

/* list.f */
verilog/rv_pkg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/writeback_stage.sv
verilog/rv_core_top.sv
tb/wb_checker.sv
tb/tb_top.sv

/* Makefile */
# Verilator simulation of the RV32I datapath slice
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
